/* pmp_cfg.svh */
// Width, channel count and address stride settings shared by the pre-modulation RTL and testbench
`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// Width of register data, period and parameter words
`define PMP_DATA_WIDTH 16

// Width of the register bus address
`define PMP_ADDR_WIDTH 8

// Number of PWM generator channels in the range 1 to 4
`define PMP_N_CHANNELS 2

// Address distance between two neighbouring channels
`define PMP_CHANNEL_STRIDE 8

`endif

/* pmp_pkg.sv */
// Modulation, register offset and parameter word types used across the pre-modulation processor
`include "pmp_cfg.svh"

package pmp_pkg;

    typedef enum logic {
        mod_phase_shift = 1'b0,
        mod_duty        = 1'b1
    } modulation_t;

    // Register offsets inside one PWM channel
    typedef enum logic [2:0] {
        reg_on       = 3'd0,
        reg_off      = 3'd1,
        reg_deadtime = 3'd2,
        reg_period   = 3'd3,
        reg_control  = 3'd4
    } pwm_reg_t;

    // Parameter word 0 is a signed phase or an unsigned duty depending on the modulation type
    typedef union packed {
        logic signed [`PMP_DATA_WIDTH-1:0] phase;
        logic        [`PMP_DATA_WIDTH-1:0] duty;
    } pwm_param_u;

    function automatic logic [`PMP_ADDR_WIDTH-1:0] reg_address(
        input int unsigned base,
        input int unsigned channel,
        input pwm_reg_t    offset
    );
        return `PMP_ADDR_WIDTH'(base + channel * `PMP_CHANNEL_STRIDE + 32'(offset));
    endfunction

endpackage

/* pmp_param_capture.sv */
// Input side that snapshots period, type and parameters on update and hands them to the operating core
`include "pmp_cfg.svh"

module pmp_param_capture (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        update,
    input  logic                        running,
    input  pmp_pkg::modulation_t        modulation_type,
    input  logic [`PMP_DATA_WIDTH-1:0]  period,
    input  logic [`PMP_DATA_WIDTH-1:0]  param_0,
    input  logic [`PMP_DATA_WIDTH-1:0]  param_1,
    output logic                        calc_req,
    output pmp_pkg::modulation_t        snap_type,
    output logic [`PMP_DATA_WIDTH-1:0]  snap_period,
    output pmp_pkg::pwm_param_u         snap_param_0,
    output logic [`PMP_DATA_WIDTH-1:0]  snap_param_1,
    input  logic                        calc_ack
);

    // An update is only taken while the modulator runs and no handoff is in flight
    logic take_update;

    assign take_update = update && running && !calc_req && !calc_ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            calc_req <= 1'b0;
        end else if (calc_req && calc_ack) begin
            calc_req <= 1'b0;
        end else if (take_update) begin
            calc_req <= 1'b1;
        end
    end

    // The snapshot stays frozen for the whole handoff
    always_ff @(posedge clock) begin
        if (take_update) begin
            snap_type    <= modulation_type;
            snap_period  <= period;
            snap_param_0 <= param_0;
            snap_param_1 <= param_1;
        end
    end

endmodule

/* pmp_management_core.sv */
// Sequencer issuing the configure, start and stop register writes and owning the modulator status
`include "pmp_cfg.svh"

module pmp_management_core #(
    parameter int unsigned PWM_BASE_ADDR = 0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       configure,
    input  logic                       start,
    input  logic                       stop,
    input  logic [`PMP_DATA_WIDTH-1:0] deadtime,
    output logic                       mgmt_req,
    output logic [`PMP_ADDR_WIDTH-1:0] mgmt_addr,
    output logic [`PMP_DATA_WIDTH-1:0] mgmt_data,
    input  logic                       mgmt_ack,
    output logic                       done,
    output logic                       modulator_status
);
    import pmp_pkg::*;

    localparam int CH_W = (`PMP_N_CHANNELS > 1) ? $clog2(`PMP_N_CHANNELS) : 1;
    localparam logic [CH_W-1:0] LAST_CH = CH_W'(`PMP_N_CHANNELS - 1);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_REQ     = 2'd1;
    localparam logic [1:0] S_RELEASE = 2'd2;

    localparam logic [1:0] CMD_CONFIGURE = 2'd0;
    localparam logic [1:0] CMD_START     = 2'd1;
    localparam logic [1:0] CMD_STOP      = 2'd2;

    logic [1:0]                 state;
    logic [1:0]                 command;
    logic [CH_W-1:0]            channel;
    logic                       configured;
    logic [`PMP_DATA_WIDTH-1:0] deadtime_q;
    pwm_reg_t                   write_reg;

    assign mgmt_req  = (state == S_REQ);
    assign write_reg = (command == CMD_CONFIGURE) ? reg_deadtime : reg_control;
    assign mgmt_addr = reg_address(PWM_BASE_ADDR, 32'(channel), write_reg);

    always_comb begin
        case (command)
            CMD_CONFIGURE: mgmt_data = deadtime_q;
            CMD_START:     mgmt_data = `PMP_DATA_WIDTH'(1);
            default:       mgmt_data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Command sequencing over all channels
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state            <= S_IDLE;
            command          <= CMD_CONFIGURE;
            channel          <= '0;
            configured       <= 1'b0;
            modulator_status <= 1'b0;
            done             <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    channel <= '0;
                    // Stop wins so the converter can always be halted
                    if (stop) begin
                        command <= CMD_STOP;
                        state   <= S_REQ;
                    end else if (start && configured) begin
                        command <= CMD_START;
                        state   <= S_REQ;
                    end else if (configure) begin
                        command <= CMD_CONFIGURE;
                        state   <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mgmt_ack) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!mgmt_ack) begin
                        if (channel == LAST_CH) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                            case (command)
                                CMD_CONFIGURE: configured       <= 1'b1;
                                CMD_START:     modulator_status <= 1'b1;
                                default:       modulator_status <= 1'b0;
                            endcase
                        end else begin
                            channel <= channel + 1'b1;
                            state   <= S_REQ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE && configure) begin
            deadtime_q <= deadtime;
        end
    end

endmodule

/* pmp_operating_core.sv */
// Computes per-channel compare values from a parameter snapshot and issues their register writes
`include "pmp_cfg.svh"

module pmp_operating_core #(
    parameter int unsigned PWM_BASE_ADDR = 0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       calc_req,
    input  pmp_pkg::modulation_t       snap_type,
    input  logic [`PMP_DATA_WIDTH-1:0] snap_period,
    input  pmp_pkg::pwm_param_u        snap_param_0,
    input  logic [`PMP_DATA_WIDTH-1:0] snap_param_1,
    input  logic                       op_ack,
    output logic                       calc_ack,
    output logic                       op_req,
    output logic [`PMP_ADDR_WIDTH-1:0] op_addr,
    output logic [`PMP_DATA_WIDTH-1:0] op_data
);
    import pmp_pkg::*;

    localparam int W    = `PMP_DATA_WIDTH;
    localparam int CH_W = (`PMP_N_CHANNELS > 1) ? $clog2(`PMP_N_CHANNELS) : 1;
    localparam logic [CH_W-1:0] LAST_CH = CH_W'(`PMP_N_CHANNELS - 1);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_REQ     = 2'd1;
    localparam logic [1:0] S_RELEASE = 2'd2;
    localparam logic [1:0] S_DONE    = 2'd3;

    logic [1:0]      state;
    logic [1:0]      slot;
    logic [CH_W-1:0] channel;
    logic [W-1:0]    half_period;
    logic [W:0]      shifted_sum;
    logic [W-1:0]    off_0, on_1, off_1;
    logic [W-1:0]    ch_on, ch_off;
    pwm_reg_t        write_reg;

    //////////////////////////////////////////////////
    // Compare value calculation
    //////////////////////////////////////////////////

    assign half_period = snap_period >> 1;

    always_comb begin
        if (snap_type == mod_phase_shift) begin
            off_0 = half_period;
            // A negative phase wraps back into the period
            on_1 = (snap_param_0.phase < 0) ? snap_param_0.duty + snap_period
                                              : snap_param_0.duty;
            shifted_sum = {1'b0, on_1} + {1'b0, half_period};
            off_1 = (shifted_sum >= {1'b0, snap_period}) ? W'(shifted_sum - {1'b0, snap_period})
                                                          : W'(shifted_sum);
        end else begin
            shifted_sum = '0;
            off_0 = (snap_param_0.duty > snap_period) ? snap_period : snap_param_0.duty;
            on_1 = '0;
            off_1 = (snap_param_1 > snap_period) ? snap_period : snap_param_1;
        end
    end

    // Even channels switch on at zero and odd channels take the channel 1 values
    assign ch_on  = channel[0] ? on_1 : '0;
    assign ch_off = channel[0] ? off_1 : off_0;

    always_comb begin
        case (slot)
            2'd0:    write_reg = reg_period;
            2'd1:    write_reg = reg_on;
            default: write_reg = reg_off;
        endcase
    end

    assign op_data  = (slot == 2'd0) ? snap_period : (slot == 2'd1) ? ch_on : ch_off;
    assign op_addr  = reg_address(PWM_BASE_ADDR, 32'(channel), write_reg);
    assign op_req   = (state == S_REQ);
    assign calc_ack = (state == S_DONE);

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= S_IDLE;
            slot    <= 2'd0;
            channel <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    slot    <= 2'd0;
                    channel <= '0;
                    if (calc_req) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (op_ack) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!op_ack) begin
                        if (slot != 2'd2) begin
                            slot  <= slot + 2'd1;
                            state <= S_REQ;
                        end else if (channel != LAST_CH) begin
                            slot    <= 2'd0;
                            channel <= channel + 1'b1;
                            state   <= S_REQ;
                        end else begin
                            state <= S_DONE;
                        end
                    end
                end
                default: begin
                    if (!calc_req) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* pmp_bus_writer.sv */
// Output side that picks one core request at a time and runs the four-phase register bus for it
`include "pmp_cfg.svh"

module pmp_bus_writer (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       mgmt_req,
    input  logic [`PMP_ADDR_WIDTH-1:0] mgmt_addr,
    input  logic [`PMP_DATA_WIDTH-1:0] mgmt_data,
    input  logic                       op_req,
    input  logic [`PMP_ADDR_WIDTH-1:0] op_addr,
    input  logic [`PMP_DATA_WIDTH-1:0] op_data,
    output logic                       mgmt_ack,
    output logic                       op_ack,
    output logic                       bus_req,
    output logic [`PMP_ADDR_WIDTH-1:0] bus_addr,
    output logic [`PMP_DATA_WIDTH-1:0] bus_data,
    input  logic                       bus_ack
);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_BUS     = 2'd1;
    localparam logic [1:0] S_RELEASE = 2'd2;
    localparam logic [1:0] S_ACK     = 2'd3;

    logic [1:0] state;
    logic       sel_op;

    assign bus_req  = (state == S_BUS);
    assign op_ack   = (state == S_ACK) && sel_op;
    assign mgmt_ack = (state == S_ACK) && !sel_op;

    // The operating core has priority and the choice is only made while idle
    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= S_IDLE;
            sel_op <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!bus_ack && (op_req || mgmt_req)) begin
                        sel_op <= op_req;
                        state  <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (bus_ack) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!bus_ack) begin
                        state <= S_ACK;
                    end
                end
                default: begin
                    if (!(sel_op ? op_req : mgmt_req)) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Address and data freeze once the writer leaves idle
    always_ff @(posedge clock) begin
        if (state == S_IDLE) begin
            bus_addr <= op_req ? op_addr : mgmt_addr;
            bus_data <= op_req ? op_data : mgmt_data;
        end
    end

endmodule

/* dab_pre_modulation_processor.sv */
// Top level of the DAB pre-modulation processor tying capture, both cores and the bus writer together
`include "pmp_cfg.svh"

module dab_pre_modulation_processor #(
    parameter int unsigned PWM_BASE_ADDR = 0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       configure,
    input  logic                       start,
    input  logic                       stop,
    input  logic                       update,
    input  pmp_pkg::modulation_t       modulation_type,
    input  logic [`PMP_DATA_WIDTH-1:0] period,
    input  logic [`PMP_DATA_WIDTH-1:0] param_0,
    input  logic [`PMP_DATA_WIDTH-1:0] param_1,
    output logic                       modulator_status,
    output logic                       done,
    output logic                       bus_req,
    output logic [`PMP_ADDR_WIDTH-1:0] bus_addr,
    output logic [`PMP_DATA_WIDTH-1:0] bus_data,
    input  logic                       bus_ack
);
    import pmp_pkg::*;

    logic                       calc_req, calc_ack;
    modulation_t                snap_type;
    logic [`PMP_DATA_WIDTH-1:0] snap_period, snap_param_1;
    pwm_param_u                 snap_param_0;
    logic                       mgmt_req, mgmt_ack, op_req, op_ack;
    logic [`PMP_ADDR_WIDTH-1:0] mgmt_addr, op_addr;
    logic [`PMP_DATA_WIDTH-1:0] mgmt_data, op_data;

    //////////////////////////////////////////////////
    // Input side and processing cores
    //////////////////////////////////////////////////

    pmp_param_capture i_param_capture (
        .clock(clock), .reset(reset), .update(update), .running(modulator_status),
        .modulation_type(modulation_type), .period(period),
        .param_0(param_0), .param_1(param_1), .calc_req(calc_req),
        .snap_type(snap_type), .snap_period(snap_period),
        .snap_param_0(snap_param_0), .snap_param_1(snap_param_1), .calc_ack(calc_ack)
    );

    // Parameter word 1 carries the deadtime when configuring
    pmp_management_core #(.PWM_BASE_ADDR(PWM_BASE_ADDR)) i_management_core (
        .clock(clock), .reset(reset), .configure(configure), .start(start), .stop(stop),
        .deadtime(param_1), .mgmt_req(mgmt_req), .mgmt_addr(mgmt_addr),
        .mgmt_data(mgmt_data), .mgmt_ack(mgmt_ack), .done(done),
        .modulator_status(modulator_status)
    );

    pmp_operating_core #(.PWM_BASE_ADDR(PWM_BASE_ADDR)) i_operating_core (
        .clock(clock), .reset(reset), .calc_req(calc_req), .snap_type(snap_type),
        .snap_period(snap_period), .snap_param_0(snap_param_0),
        .snap_param_1(snap_param_1), .op_ack(op_ack), .calc_ack(calc_ack),
        .op_req(op_req), .op_addr(op_addr), .op_data(op_data)
    );

    pmp_bus_writer i_bus_writer (
        .clock(clock), .reset(reset),
        .mgmt_req(mgmt_req), .mgmt_addr(mgmt_addr), .mgmt_data(mgmt_data),
        .op_req(op_req), .op_addr(op_addr), .op_data(op_data),
        .mgmt_ack(mgmt_ack), .op_ack(op_ack),
        .bus_req(bus_req), .bus_addr(bus_addr), .bus_data(bus_data), .bus_ack(bus_ack)
    );

endmodule

/* tb_pwm_bank_model.sv */
// Testbench PWM register bank that acknowledges four-phase bus writes after a pseudo-random delay
`include "pmp_cfg.svh"

module tb_pwm_bank_model (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       bus_req,
    input  logic [`PMP_ADDR_WIDTH-1:0] bus_addr,
    input  logic [`PMP_DATA_WIDTH-1:0] bus_data,
    output logic                       bus_ack,
    output logic [`PMP_DATA_WIDTH-1:0] regs [0:(1 << `PMP_ADDR_WIDTH)-1]
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 1 << `PMP_ADDR_WIDTH;

    logic [31:0] rng_state;
    logic [31:0] rng_next;
    logic [2:0]  wait_left;
    logic        busy;
    logic        store;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign rng_next = xorshift32(rng_state);
    assign store    = bus_req && !bus_ack && busy && (wait_left == 3'd0);

    // Each request draws a fresh delay of 0 to 7 cycles before the ack
    always_ff @(posedge clock) begin
        if (reset) begin
            bus_ack   <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 3'd0;
            rng_state <= 32'd59;
        end else if (bus_ack) begin
            if (!bus_req) begin
                bus_ack <= 1'b0;
            end
        end else if (bus_req && !busy) begin
            busy      <= 1'b1;
            rng_state <= rng_next;
            wait_left <= rng_next[2:0];
        end else if (busy && wait_left != 3'd0) begin
            wait_left <= wait_left - 3'd1;
        end else if (store) begin
            bus_ack <= 1'b1;
            busy    <= 1'b0;
        end
    end

    // The fill pattern carries the full address so stray writes show up
    always @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < DEPTH; a++) begin
                regs[a] = `PMP_DATA_WIDTH'(32'hc000 | a);
            end
        end else if (store) begin
            regs[bus_addr] = bus_data;
        end
    end

endmodule

/* tb_dab_pre_modulation_processor.sv */
// Testbench top that replays the command patterns on the pre-modulation processor and checks the bank
`include "pmp_cfg.svh"

module tb_dab_pre_modulation_processor;
    timeunit 1ns;
    timeprecision 100ps;
    import pmp_pkg::*;

    localparam int W          = `PMP_DATA_WIDTH;
    localparam int A          = `PMP_ADDR_WIDTH;
    localparam int MAX_CMDS   = 64;
    localparam int BANK_DEPTH = 1 << A;
    localparam int K_CONFIGURE = 0;
    localparam int K_START     = 1;
    localparam int K_STOP      = 2;
    localparam int K_UPDATE    = 3;
    // Register offsets inside one channel
    localparam int REG_ON       = 0;
    localparam int REG_OFF      = 1;
    localparam int REG_DEADTIME = 2;
    localparam int REG_PERIOD   = 3;
    localparam int REG_CONTROL  = 4;

    logic         clock, reset, configure, start, stop, update;
    modulation_t  modulation_type;
    logic [W-1:0] period, param_0, param_1;
    logic         modulator_status, done, bus_req, bus_ack;
    logic [A-1:0] bus_addr;
    logic [W-1:0] bus_data;
    logic [W-1:0] bank_regs [0:BANK_DEPTH-1];

    // Per command fields are type, period, param_0, param_1, on_0, off_0, on_1, off_1
    int           kinds [0:MAX_CMDS-1];
    logic [W-1:0] fields [0:MAX_CMDS-1][0:7];
    int           n_cmds;
    int           cycle_count;
    int           cycle_limit;
    logic         running;
    logic [W-1:0] last_period;
    logic         prev_req;
    logic [A-1:0] prev_addr;
    logic [W-1:0] prev_data;

    dab_pre_modulation_processor i_dab_pre_modulation_processor (
        .clock(clock), .reset(reset), .configure(configure), .start(start), .stop(stop),
        .update(update), .modulation_type(modulation_type), .period(period),
        .param_0(param_0), .param_1(param_1), .modulator_status(modulator_status),
        .done(done), .bus_req(bus_req), .bus_addr(bus_addr), .bus_data(bus_data),
        .bus_ack(bus_ack)
    );

    tb_pwm_bank_model i_bank (
        .clock(clock), .reset(reset), .bus_req(bus_req), .bus_addr(bus_addr),
        .bus_data(bus_data), .bus_ack(bus_ack), .regs(bank_regs)
    );

    always #2 clock = ~clock;

    //////////////////////////////////////////////////
    // Error reporting and checks
    //////////////////////////////////////////////////

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    function automatic int channel_addr(input int channel, input int offset);
        return channel * `PMP_CHANNEL_STRIDE + offset;
    endfunction

    // Cycle counter from the end of reset with a limit that scales with the command count
    always @(posedge clock) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                stop_on_error($sformatf("Timeout after %0d cycles waiting for the DUT",
                                        cycle_count));
            end
        end
    end

    // The bus protocol monitor samples mid-cycle when all signals have settled
    always @(negedge clock) begin
        if (!reset) begin
            if (bus_req && !prev_req && bus_ack) begin
                stop_on_error("The bus request rose while the bank ack was still high");
            end
            if (bus_req && prev_req) begin
                check_value("bus_addr", 32'(bus_addr), 32'(prev_addr));
                check_value("bus_data", 32'(bus_data), 32'(prev_data));
            end
        end
        prev_req  <= bus_req;
        prev_addr <= bus_addr;
        prev_data <= bus_data;
    end

    //////////////////////////////////////////////////
    // Pattern loading and command driving
    //////////////////////////////////////////////////

    task automatic load_patterns();
        int            fd;
        int            code;
        logic [127:0]  word;
        logic [1023:0] skip_line;
        logic [W-1:0]  value;
        fd = $fopen("dab_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the pattern file dab_patterns.txt");
        end
        n_cmds = 0;
        code = $fscanf(fd, "%s", word);
        while (code == 1) begin
            if (word == "#") begin
                code = $fgets(skip_line, fd);
            end else begin
                if (n_cmds == MAX_CMDS) begin
                    stop_on_error("The pattern file holds too many commands");
                end
                if (word == "configure") begin
                    kinds[n_cmds] = K_CONFIGURE;
                end else if (word == "start") begin
                    kinds[n_cmds] = K_START;
                end else if (word == "stop") begin
                    kinds[n_cmds] = K_STOP;
                end else if (word == "update") begin
                    kinds[n_cmds] = K_UPDATE;
                end else begin
                    stop_on_error("The pattern file holds an unknown command");
                end
                for (int f = 0; f < 8; f++) begin
                    fields[n_cmds][f] = '0;
                end
                // Configure carries only the deadtime in the param_1 slot
                if (kinds[n_cmds] == K_CONFIGURE) begin
                    code = $fscanf(fd, "%h", value);
                    if (code != 1) begin
                        stop_on_error("A configure line lacks its deadtime");
                    end
                    fields[n_cmds][3] = value;
                end else if (kinds[n_cmds] == K_UPDATE) begin
                    for (int f = 0; f < 8; f++) begin
                        code = $fscanf(fd, "%h", value);
                        if (code != 1) begin
                            stop_on_error("An update line has too few values");
                        end
                        fields[n_cmds][f] = value;
                    end
                end
                n_cmds++;
            end
            code = $fscanf(fd, "%s", word);
        end
        $fclose(fd);
        cycle_limit = n_cmds * 200;
    endtask

    task automatic issue_pulse(input int kind);
        @(posedge clock);
        #1;
        case (kind)
            K_CONFIGURE: configure = 1'b1;
            K_START:     start = 1'b1;
            K_STOP:      stop = 1'b1;
            default:     update = 1'b1;
        endcase
        @(posedge clock);
        #1;
        configure = 1'b0;
        start     = 1'b0;
        stop      = 1'b0;
        update    = 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(posedge clock);
            #1;
        end while (!done);
    endtask

    // The bank counts as settled after 20 cycles without bus activity
    task automatic wait_bank_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 20) begin
            @(posedge clock);
            #1;
            if (bus_req || bus_ack) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic check_all_channels(input int offset, input logic [W-1:0] expected,
                                      input string what);
        for (int ch = 0; ch < `PMP_N_CHANNELS; ch++) begin
            check_value($sformatf("channel %0d %s register", ch, what),
                        32'(bank_regs[channel_addr(ch, offset)]), 32'(expected));
        end
    endtask

    task automatic run_command(input int idx);
        logic [W-1:0] exp_period;
        case (kinds[idx])
            K_CONFIGURE: begin
                param_1 = fields[idx][3];
                issue_pulse(K_CONFIGURE);
                wait_done();
                check_all_channels(REG_DEADTIME, fields[idx][3], "deadtime");
                check_value("modulator_status", 32'(modulator_status), 32'd0);
            end
            K_START: begin
                issue_pulse(K_START);
                wait_done();
                running = 1'b1;
                check_all_channels(REG_CONTROL, W'(1), "control");
                check_value("modulator_status", 32'(modulator_status), 32'd1);
            end
            K_STOP: begin
                issue_pulse(K_STOP);
                wait_done();
                running = 1'b0;
                check_all_channels(REG_CONTROL, W'(0), "control");
                check_value("modulator_status", 32'(modulator_status), 32'd0);
            end
            default: begin
                modulation_type = modulation_t'(fields[idx][0][0]);
                period  = fields[idx][1];
                param_0 = fields[idx][2];
                param_1 = fields[idx][3];
                issue_pulse(K_UPDATE);
                wait_bank_quiet();
                // A stopped modulator drops the update and the period stays put
                if (running) begin
                    last_period = fields[idx][1];
                end
                exp_period = last_period;
                check_all_channels(REG_PERIOD, exp_period, "period");
                for (int ch = 0; ch < `PMP_N_CHANNELS; ch++) begin
                    check_value($sformatf("channel %0d on register", ch),
                                32'(bank_regs[channel_addr(ch, REG_ON)]),
                                32'(fields[idx][4 + 2 * (ch % 2)]));
                    check_value($sformatf("channel %0d off register", ch),
                                32'(bank_regs[channel_addr(ch, REG_OFF)]),
                                32'(fields[idx][5 + 2 * (ch % 2)]));
                end
            end
        endcase
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        configure       = 1'b0;
        start           = 1'b0;
        stop            = 1'b0;
        update          = 1'b0;
        modulation_type = mod_phase_shift;
        period          = '0;
        param_0         = '0;
        param_1         = '0;
        running         = 1'b0;
        last_period     = '0;
        cycle_count     = 0;
        cycle_limit     = 0;
        load_patterns();
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_cmds; i++) begin
            run_command(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* dab_patterns.txt */
# Commands: configure <deadtime> | start | stop | update <type> <period> <param_0> <param_1> ...
# Update values in hex after the type: period param_0 param_1 on_0 off_0 on_1 off_1
configure 0005
start
update 0 0100 0040 0000 0000 0080 0040 00c0
update 0 0100 00a0 0000 0000 0080 00a0 0020
update 0 0100 ffd0 0000 0000 0080 00d0 0050
update 1 00c8 0064 0190 0000 0064 0000 00c8
stop
update 0 0100 0040 0000 0000 0064 0000 00c8

/* dab_pre_modulation_processor.f */
+incdir+.
pmp_pkg.sv
pmp_param_capture.sv
pmp_management_core.sv
pmp_operating_core.sv
pmp_bus_writer.sv
dab_pre_modulation_processor.sv
tb_pwm_bank_model.sv
tb_dab_pre_modulation_processor.sv

/* Makefile */
# Verilator flow for the DAB pre-modulation processor

VERILATOR ?= verilator
TB_TOP    ?= tb_dab_pre_modulation_processor
RTL_TOP   ?= dab_pre_modulation_processor
FILELIST  ?= dab_pre_modulation_processor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/100ps
PASS_MSG  ?= test passed

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
